// ==== Makefile ====
# Verilator simulation of the I3C register file testbench

TOP := tb_i3c_regf_top
LOG := sim.log

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== tb.f ====
+incdir+verilog
verilog/regf_pkg.sv
verilog/regf_apb_slave.sv
verilog/regf_storage.sv
verilog/regf_cmd_decoder.sv
verilog/i3c_regf_top.sv
verif/tb_i3c_regf_top.sv

// ==== verif/tb_i3c_regf_top.sv ====
// Directed testbench with clock, reset, APB tasks, check task and six tests for the I3C register file top
`timescale 1ns/100ps
`include "regf_config.svh"

module tb_i3c_regf_top;

  logic        i_regf_clk;
  logic        i_regf_rst_n;
  logic        i_apb_psel;
  logic        i_apb_penable;
  logic        i_apb_pwrite;
  logic [8:0]  i_apb_paddr;
  logic [7:0]  i_apb_pwdata;
  logic [7:0]  o_apb_prdata;
  logic        o_apb_pready;
  logic        o_apb_pslverr;
  logic        i_engine_cmd_req;
  logic        i_engine_dummy_sel;
  logic [7:0]  o_regf_num_frames;
  logic        o_ser_rx_tx;
  logic [7:0]  o_regf_ibi_cfg;
  logic [7:0]  o_regf_ibi_payload_size;
  logic [7:0]  o_ibi_tgt_address;
  logic [7:0]  o_crh_tgts_count;
  logic [2:0]  o_regf_hj_cfg;
  logic        o_regf_hj_support;
  logic        o_cmd_valid;
  logic        o_cmd_err;
  logic [2:0]  o_cmd_attr;
  logic [3:0]  o_cmd_tid;
  logic [7:0]  o_cmd_ccc;
  logic [4:0]  o_cmd_dev_index;
  logic [2:0]  o_cmd_mode;
  logic        o_cmd_rnw;
  logic        o_cmd_wroc;
  logic        o_cmd_toc;
  logic [15:0] o_cmd_data_len;
  logic [31:0] o_cmd_imm_data;

  // Register bytes read back after reset
  logic [8:0] addr_list [12] = '{`REGF_TARGET_ADDR, `REGF_NUM_FRAMES, `REGF_TGTS_COUNT,
    `REGF_BDCST_ADDR, `REGF_ARB_ADDR, `REGF_IBI_CFG, `REGF_IBI_PAYLOAD, `REGF_ENEC_BYTE,
    `REGF_DISEC_BYTE, `REGF_HJ_CFG, `REGF_CRCAP1, 9'd200};

  i3c_regf_top i_i3c_regf_top (.*);

  initial
  begin
    i_regf_clk = 1'b0;
    forever #4 i_regf_clk = ~i_regf_clk;  // 8 ns period
  end

  ////////////////////////////////////////////////////////////
  // Expected values and checking
  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Stopped at first mismatch");
    end
  endtask

  function automatic logic [7:0] enec_expect(input logic hj);
    return 8'h03 | {4'b0, hj, 3'b0};      // ENINT, ENCR kept; ENHJ follows hj
  endfunction

  function automatic logic [7:0] disec_expect(input logic hj);
    return {4'b0, ~hj, 3'b0};
  endfunction

  function automatic logic [7:0] default_byte(input logic [8:0] a);
    case (a)
      `REGF_TARGET_ADDR:          return 8'hA8;
      `REGF_NUM_FRAMES:           return 8'h02;
      `REGF_BDCST_ADDR:           return 8'hFC;
      `REGF_ARB_ADDR:             return 8'h53;
      `REGF_IBI_CFG:              return 8'h01;
      `REGF_IBI_PAYLOAD:          return 8'h03;
      `REGF_TGTS_COUNT:           return 8'h02;
      `REGF_ENEC_BYTE:            return enec_expect(1'b0);  // CRCAP1 bit 0 low
      `REGF_DISEC_BYTE:           return disec_expect(1'b0);
      `REGF_HJ_CFG:               return 8'h07;
      `REGF_DUMMY_DESC:           return 8'h81;
      `REGF_DUMMY_DESC + 9'd1:    return 8'h8F;
      `REGF_DUMMY_DESC + 9'd3:    return 8'h18;
      default:                    return 8'h00;
    endcase
  endfunction

  function automatic bit is_special(input logic [8:0] a);
    return (default_byte(a) != 8'h00) || (a == `REGF_CRCAP1) || (a == `REGF_DISEC_BYTE) ||
           ((a >= `REGF_NORMAL_DESC) && (a < `REGF_NORMAL_DESC + 9'd8)) ||
           ((a >= `REGF_DUMMY_DESC) && (a < `REGF_DUMMY_DESC + 9'd8));
  endfunction

  ////////////////////////////////////////////////////////////
  // APB host side
  task automatic wait_ready(input string kind);
    int cycles;
    cycles = 0;
    @(negedge i_regf_clk);                // Sample mid-cycle
    while (!o_apb_pready)
    begin
      cycles++;
      if (cycles > 16)
      begin
        $display("APB %s at %0t ns saw no pready within 16 cycles", kind, $time);
        $display(">>> FAIL");
        $fatal(1, "APB handshake timed out");
      end
      @(negedge i_regf_clk);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [8:0] a, input logic [7:0] d,
                          output logic [7:0] rd, output logic err);
    @(posedge i_regf_clk);
    i_apb_psel    <= 1'b1;                // Setup
    i_apb_penable <= 1'b0;
    i_apb_pwrite  <= wr;
    i_apb_paddr   <= a;
    i_apb_pwdata  <= d;
    @(posedge i_regf_clk);
    i_apb_penable <= 1'b1;                // Access
    wait_ready(wr ? "write" : "read");
    rd  = o_apb_prdata;
    err = o_apb_pslverr;
    @(posedge i_regf_clk);
    i_apb_psel    <= 1'b0;
    i_apb_penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [8:0] a, input logic [7:0] d, input logic exp_err);
    logic [7:0] unused;
    logic       err;
    apb_xfer(1'b1, a, d, unused, err);
    check_eq($sformatf("pslverr on write to %0d", a), err, exp_err);
  endtask

  task automatic apb_read(input logic [8:0] a, input logic [7:0] exp);
    logic [7:0] rd;
    logic       err;
    apb_xfer(1'b0, a, 8'h00, rd, err);
    check_eq($sformatf("read of byte %0d", a), rd, exp);
    check_eq("pslverr on read", err, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Descriptor helpers
  task automatic write_desc(input logic [31:0] dw0, input logic [31:0] dw1);
    logic [63:0] d;
    d = {dw1, dw0};                       // Little-endian from the base
    for (int i = 0; i < 8; i++)
      apb_write(`REGF_NORMAL_DESC + 9'(i), d[8*i +: 8], 1'b0);
  endtask

  task automatic check_decode(input string what, input logic [31:0] dw0, input logic [31:0] dw1);
    logic [2:0]  attr;
    logic [2:0]  dtt;
    logic        err;
    logic [15:0] len;
    logic [31:0] imm;
    attr = dw0[2:0];
    dtt  = dw0[25:23];
    len  = dw1[31:16];                    // Regular view
    imm  = 32'h0;
    err  = (attr != `REGF_ATTR_REGULAR) && (attr != `REGF_ATTR_IMMEDIATE);
    if (attr == `REGF_ATTR_IMMEDIATE)
    begin
      len = {13'd0, dtt};
      err = (dtt > 3'd4);
      for (int k = 0; k < 4; k++)
        if (k < dtt)
          imm[8*k +: 8] = dw1[8*k +: 8];  // Bytes below DTT survive
    end
    check_eq({what, " valid"}, o_cmd_valid, 1'b1);
    check_eq({what, " err"}, o_cmd_err, err);
    if (!err)
    begin
      check_eq({what, " attr"}, o_cmd_attr, attr);
      check_eq({what, " tid"}, o_cmd_tid, dw0[6:3]);
      check_eq({what, " ccc"}, o_cmd_ccc, dw0[15] ? dw0[14:7] : 8'h00);
      check_eq({what, " dev_index"}, o_cmd_dev_index, dw0[20:16]);
      check_eq({what, " mode"}, o_cmd_mode, dw0[28:26]);
      check_eq({what, " rnw/wroc/toc"}, {o_cmd_toc, o_cmd_wroc, o_cmd_rnw}, dw0[31:29]);
      check_eq({what, " data_len"}, o_cmd_data_len, len);
      check_eq({what, " imm_data"}, o_cmd_imm_data, imm);
    end
  endtask

  task automatic request_check(input logic sel, input logic [31:0] dw0, input logic [31:0] dw1,
                               input string what);
    @(posedge i_regf_clk);
    i_engine_cmd_req   <= 1'b1;
    i_engine_dummy_sel <= sel;
    @(posedge i_regf_clk);
    i_engine_cmd_req   <= 1'b0;
    @(negedge i_regf_clk);                // Cycle after the request
    check_decode(what, dw0, dw1);
    @(negedge i_regf_clk);
    check_eq({what, " valid drops"}, o_cmd_valid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  task automatic reset_defaults();
    check_eq("pready after reset", o_apb_pready, 1'b0);
    check_eq("pslverr after reset", o_apb_pslverr, 1'b0);
    check_eq("cmd valid/err after reset", {o_cmd_valid, o_cmd_err}, 2'b00);
    check_eq("cmd fields after reset", {o_cmd_attr, o_cmd_tid, o_cmd_ccc, o_cmd_dev_index,
                                        o_cmd_mode, o_cmd_rnw, o_cmd_wroc, o_cmd_toc}, 32'h0);
    check_eq("cmd data_len after reset", o_cmd_data_len, 16'h0);
    check_eq("cmd imm_data after reset", o_cmd_imm_data, 32'h0);
    check_eq("num_frames", o_regf_num_frames, 8'h02);
    check_eq("ibi_cfg", o_regf_ibi_cfg, 8'h01);
    check_eq("payload size", o_regf_ibi_payload_size, 8'h03);
    check_eq("ibi target address", o_ibi_tgt_address, 8'h53);
    check_eq("tgts_count", o_crh_tgts_count, 8'h02);
    check_eq("ser_rx_tx", o_ser_rx_tx, 1'b0);
    check_eq("hj_cfg", o_regf_hj_cfg, 3'd7);
    check_eq("hj_support", o_regf_hj_support, 1'b0);
    foreach (addr_list[i])
      apb_read(addr_list[i], default_byte(addr_list[i]));
    for (int i = 0; i < 8; i++)
      apb_read(`REGF_DUMMY_DESC + 9'(i), default_byte(`REGF_DUMMY_DESC + 9'(i)));
  endtask

  task automatic read_back();
    logic [8:0] a;
    logic [7:0] d;
    for (int n = 0; n < 12; n++)
    begin
      do
        a = 9'($urandom);
      while (is_special(a));
      d = 8'($urandom_range(255, 1));     // Nonzero so a lost write shows
      apb_write(a, d, 1'b0);
      apb_read(a, d);
    end
    d = 8'($urandom) | 8'h80;             // Never the default frame count
    apb_write(`REGF_NUM_FRAMES, d, 1'b0);
    @(negedge i_regf_clk);                // Write edge just passed
    check_eq("num_frames before refresh", o_regf_num_frames, 8'h02);
    @(negedge i_regf_clk);
    check_eq("num_frames after refresh", o_regf_num_frames, d);
  endtask

  task automatic read_only_protect();
    apb_write(`REGF_ENEC_BYTE, 8'hFF, 1'b1);
    apb_read(`REGF_ENEC_BYTE, enec_expect(1'b0));
    apb_write(`REGF_DISEC_BYTE, 8'hF7, 1'b1);
    apb_read(`REGF_DISEC_BYTE, disec_expect(1'b0));
    for (int i = 0; i < 8; i++)
    begin
      apb_write(`REGF_DUMMY_DESC + 9'(i), ~default_byte(`REGF_DUMMY_DESC + 9'(i)), 1'b1);
      apb_read(`REGF_DUMMY_DESC + 9'(i), default_byte(`REGF_DUMMY_DESC + 9'(i)));
    end
  endtask

  task automatic hot_join_bits();
    logic c;
    logic h;
    for (int i = 0; i < 4; i++)
    begin
      c = i[0];
      h = i[1];
      apb_write(`REGF_CRCAP1, {7'd0, c}, 1'b0);
      apb_write(`REGF_HJ_CFG, {5'd0, 1'b1, h, 1'b1}, 1'b0);
      apb_read(`REGF_ENEC_BYTE, enec_expect(c & h));
      apb_read(`REGF_DISEC_BYTE, disec_expect(c & h));
      check_eq("hj_support", o_regf_hj_support, c);
      check_eq("hj_cfg", o_regf_hj_cfg, {1'b1, h, 1'b1});
    end
    apb_write(`REGF_CRCAP1, 8'h00, 1'b0);  // Back to defaults
    apb_write(`REGF_HJ_CFG, 8'h07, 1'b0);
  endtask

  task automatic regular_descriptors();
    logic [31:0] dw0;
    logic [31:0] dw1;
    for (int n = 0; n < 6; n++)
    begin
      dw0      = $urandom;
      dw0[2:0] = `REGF_ATTR_REGULAR;
      dw1      = $urandom;
      write_desc(dw0, dw1);
      request_check(1'b0, dw0, dw1, "regular");
    end
  endtask

  task automatic immediate_and_dummy();
    logic [31:0] dw0;
    logic [31:0] dw1;
    request_check(1'b1, 32'h18008F81, 32'h0, "dummy");
    for (int t = 0; t <= 5; t++)          // DTT 5 is malformed
    begin
      dw0        = $urandom;
      dw0[2:0]   = `REGF_ATTR_IMMEDIATE;
      dw0[25:23] = 3'(t);
      dw1        = $urandom;
      write_desc(dw0, dw1);
      request_check(1'b0, dw0, dw1, $sformatf("immediate dtt %0d", t));
    end
    dw0[2:0] = 3'd3;                      // Unknown attribute
    write_desc(dw0, dw1);
    request_check(1'b0, dw0, dw1, "attr 3");
    // Back-to-back normal then dummy requests
    dw0[2:0] = `REGF_ATTR_REGULAR;
    write_desc(dw0, dw1);
    @(posedge i_regf_clk);
    i_engine_cmd_req   <= 1'b1;
    i_engine_dummy_sel <= 1'b0;
    @(posedge i_regf_clk);
    i_engine_dummy_sel <= 1'b1;           // Second request with no gap
    @(negedge i_regf_clk);
    check_decode("back-to-back first", dw0, dw1);
    @(posedge i_regf_clk);
    i_engine_cmd_req   <= 1'b0;
    i_engine_dummy_sel <= 1'b0;
    @(negedge i_regf_clk);
    check_decode("back-to-back second", 32'h18008F81, 32'h0);
    @(negedge i_regf_clk);
    check_eq("back-to-back valid drops", o_cmd_valid, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    void'($urandom(1286));
    i_regf_rst_n       = 1'b0;
    i_apb_psel         = 1'b0;
    i_apb_penable      = 1'b0;
    i_apb_pwrite       = 1'b0;
    i_apb_paddr        = '0;
    i_apb_pwdata       = '0;
    i_engine_cmd_req   = 1'b0;
    i_engine_dummy_sel = 1'b0;
    repeat (16) @(posedge i_regf_clk);
    i_regf_rst_n <= 1'b1;
    @(negedge i_regf_clk);                // First cycle out of reset
    reset_defaults();
    read_back();
    read_only_protect();
    hot_join_bits();
    regular_descriptors();
    immediate_and_dummy();
    repeat (2) @(posedge i_regf_clk);
    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== verilog/i3c_regf_top.sv ====
// I3C controller configuration block top: APB completer, storage and decoder
`timescale 1ns/100ps
`include "regf_config.svh"

module i3c_regf_top (
  input  logic                i_regf_clk,
  input  logic                i_regf_rst_n,
  // APB
  input  logic                i_apb_psel,
  input  logic                i_apb_penable,
  input  logic                i_apb_pwrite,
  input  logic [`REGF_AW-1:0] i_apb_paddr,
  input  logic [7:0]          i_apb_pwdata,
  output logic [7:0]          o_apb_prdata,
  output logic                o_apb_pready,
  output logic                o_apb_pslverr,
  // Engine
  input  logic                i_engine_cmd_req,
  input  logic                i_engine_dummy_sel,
  // Live configuration
  output logic [7:0]          o_regf_num_frames,
  output logic                o_ser_rx_tx,
  output logic [7:0]          o_regf_ibi_cfg,
  output logic [7:0]          o_regf_ibi_payload_size,
  output logic [7:0]          o_ibi_tgt_address,
  output logic [7:0]          o_crh_tgts_count,
  output logic [2:0]          o_regf_hj_cfg,
  output logic                o_regf_hj_support,
  // Decoded command
  output logic                o_cmd_valid,
  output logic                o_cmd_err,
  output logic [2:0]          o_cmd_attr,
  output logic [3:0]          o_cmd_tid,
  output logic [7:0]          o_cmd_ccc,
  output logic [4:0]          o_cmd_dev_index,
  output logic [2:0]          o_cmd_mode,
  output logic                o_cmd_rnw,
  output logic                o_cmd_wroc,
  output logic                o_cmd_toc,
  output logic [15:0]         o_cmd_data_len,
  output logic [31:0]         o_cmd_imm_data
);

  logic                rd_en;
  logic                wr_en;
  logic                wr_ro;
  logic [`REGF_AW-1:0] addr;
  logic [7:0]          wdata;
  logic [7:0]          rdata;
  logic [31:0]         desc_dw0;
  regf_pkg::regf_dw1_u desc_dw1;

  regf_apb_slave u_apb (
    .i_regf_clk   (i_regf_clk),    .i_regf_rst_n (i_regf_rst_n),
    .i_apb_psel   (i_apb_psel),    .i_apb_penable(i_apb_penable),
    .i_apb_pwrite (i_apb_pwrite),  .i_apb_paddr  (i_apb_paddr),
    .i_apb_pwdata (i_apb_pwdata),  .i_regf_rdata (rdata),
    .i_regf_wr_ro (wr_ro),         .o_apb_prdata (o_apb_prdata),
    .o_apb_pready (o_apb_pready),  .o_apb_pslverr(o_apb_pslverr),
    .o_regf_rd_en (rd_en),         .o_regf_wr_en (wr_en),
    .o_regf_addr  (addr),          .o_regf_wdata (wdata)
  );

  regf_storage u_storage (
    .i_regf_clk        (i_regf_clk),       .i_regf_rst_n     (i_regf_rst_n),
    .i_regf_rd_en      (rd_en),            .i_regf_wr_en     (wr_en),
    .i_regf_addr       (addr),             .i_regf_data_wr   (wdata),
    .i_engine_dummy_sel(i_engine_dummy_sel), .o_regf_data_rd (rdata),
    .o_regf_wr_ro      (wr_ro),            .o_desc_dw0       (desc_dw0),
    .o_desc_dw1        (desc_dw1),         .o_regf_num_frames(o_regf_num_frames),
    .o_ser_rx_tx       (o_ser_rx_tx),      .o_regf_ibi_cfg   (o_regf_ibi_cfg),
    .o_regf_ibi_payload_size(o_regf_ibi_payload_size),
    .o_ibi_tgt_address (o_ibi_tgt_address), .o_crh_tgts_count(o_crh_tgts_count),
    .o_regf_hj_cfg     (o_regf_hj_cfg),    .o_regf_hj_support(o_regf_hj_support)
  );

  regf_cmd_decoder u_decoder (
    .i_regf_clk      (i_regf_clk),       .i_regf_rst_n   (i_regf_rst_n),
    .i_engine_cmd_req(i_engine_cmd_req), .i_desc_dw0     (desc_dw0),
    .i_desc_dw1      (desc_dw1),         .o_cmd_valid    (o_cmd_valid),
    .o_cmd_err       (o_cmd_err),        .o_cmd_attr     (o_cmd_attr),
    .o_cmd_tid       (o_cmd_tid),        .o_cmd_ccc      (o_cmd_ccc),
    .o_cmd_dev_index (o_cmd_dev_index),  .o_cmd_mode     (o_cmd_mode),
    .o_cmd_rnw       (o_cmd_rnw),        .o_cmd_wroc     (o_cmd_wroc),
    .o_cmd_toc       (o_cmd_toc),        .o_cmd_data_len (o_cmd_data_len),
    .o_cmd_imm_data  (o_cmd_imm_data)
  );

endmodule

// ==== verilog/regf_apb_slave.sv ====
// APB completer producing register file read and write strobes
`timescale 1ns/100ps
`include "regf_config.svh"

module regf_apb_slave (
  input  logic                i_regf_clk,
  input  logic                i_regf_rst_n,
  input  logic                i_apb_psel,
  input  logic                i_apb_penable,
  input  logic                i_apb_pwrite,
  input  logic [`REGF_AW-1:0] i_apb_paddr,
  input  logic [7:0]          i_apb_pwdata,
  input  logic [7:0]          i_regf_rdata,   // Registered in storage
  input  logic                i_regf_wr_ro,   // Address is read-only
  output logic [7:0]          o_apb_prdata,
  output logic                o_apb_pready,
  output logic                o_apb_pslverr,
  output logic                o_regf_rd_en,
  output logic                o_regf_wr_en,
  output logic [`REGF_AW-1:0] o_regf_addr,
  output logic [7:0]          o_regf_wdata
);

  logic setup_ph;   // psel without penable
  logic access_ph;  // psel with penable

  assign setup_ph  = i_apb_psel & ~i_apb_penable;
  assign access_ph = i_apb_psel &  i_apb_penable;

  ////////////////////////////////////////////////////////////
  // Strobes to storage
  assign o_regf_rd_en = setup_ph & ~i_apb_pwrite;  // Byte lands for access
  assign o_regf_wr_en = access_ph & i_apb_pwrite;  // Written on access edge
  assign o_regf_addr  = i_apb_paddr;
  assign o_regf_wdata = i_apb_pwdata;
  assign o_apb_prdata = i_regf_rdata;

  // Response flags, set up one cycle ahead so they sit in the access cycle
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_apb_pready  <= 1'b0;
      o_apb_pslverr <= 1'b0;
    end
    else
    begin
      o_apb_pready  <= setup_ph;                          // No wait states
      o_apb_pslverr <= setup_ph & i_apb_pwrite & i_regf_wr_ro;
    end
  end

  // Access phase must follow a setup phase
  a_penable_after_psel : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    $rose(i_apb_penable) |-> $past(i_apb_psel)
  );

endmodule

// ==== verilog/regf_cmd_decoder.sv ====
// Command descriptor decoder with malformed-command flag
`timescale 1ns/100ps
`include "regf_config.svh"

module regf_cmd_decoder (
  input  logic                i_regf_clk,
  input  logic                i_regf_rst_n,
  input  logic                i_engine_cmd_req,
  input  logic [31:0]         i_desc_dw0,
  input  regf_pkg::regf_dw1_u i_desc_dw1,
  output logic                o_cmd_valid,
  output logic                o_cmd_err,
  output logic [2:0]          o_cmd_attr,
  output logic [3:0]          o_cmd_tid,
  output logic [7:0]          o_cmd_ccc,
  output logic [4:0]          o_cmd_dev_index,
  output logic [2:0]          o_cmd_mode,
  output logic                o_cmd_rnw,
  output logic                o_cmd_wroc,
  output logic                o_cmd_toc,
  output logic [15:0]         o_cmd_data_len,
  output logic [31:0]         o_cmd_imm_data
);

  logic [2:0]  attr;
  logic [2:0]  dtt;          // Immediate byte count
  logic        is_imm;
  logic        bad_cmd;
  logic [31:0] imm_masked;

  assign attr    = i_desc_dw0[2:0];
  assign dtt     = i_desc_dw0[25:23];
  assign is_imm  = (attr == `REGF_ATTR_IMMEDIATE);
  assign bad_cmd = ((attr != `REGF_ATTR_REGULAR) && !is_imm) ||
                   (is_imm && (dtt > 3'd4));

  // Zero bytes at or above DTT
  always_comb
  begin
    imm_masked = i_desc_dw1.imm;
    for (int k = 0; k < 4; k++)
      if (k >= dtt)
        imm_masked[8*k +: 8] = 8'h00;
  end

  ////////////////////////////////////////////////////////////
  // Field capture on request
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_cmd_valid     <= 1'b0;
      o_cmd_err       <= 1'b0;
      o_cmd_attr      <= '0;
      o_cmd_tid       <= '0;
      o_cmd_ccc       <= '0;
      o_cmd_dev_index <= '0;
      o_cmd_mode      <= '0;
      o_cmd_rnw       <= 1'b0;
      o_cmd_wroc      <= 1'b0;
      o_cmd_toc       <= 1'b0;
      o_cmd_data_len  <= '0;
      o_cmd_imm_data  <= '0;
    end
    else
    begin
      o_cmd_valid <= i_engine_cmd_req;              // One-cycle pulse
      o_cmd_err   <= i_engine_cmd_req & bad_cmd;
      if (i_engine_cmd_req)
      begin
        o_cmd_attr      <= attr;
        o_cmd_tid       <= i_desc_dw0[6:3];
        o_cmd_ccc       <= i_desc_dw0[15] ? i_desc_dw0[14:7] : 8'h00;  // Only with CP
        o_cmd_dev_index <= i_desc_dw0[20:16];
        o_cmd_mode      <= i_desc_dw0[28:26];
        o_cmd_rnw       <= i_desc_dw0[29];
        o_cmd_wroc      <= i_desc_dw0[30];
        o_cmd_toc       <= i_desc_dw0[31];
        o_cmd_data_len  <= is_imm ? {13'd0, dtt} : i_desc_dw1.xfer.data_len;
        o_cmd_imm_data  <= is_imm ? imm_masked : 32'h0;
      end
    end
  end

  // Error flag only rides on a valid command
  a_err_with_valid : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    o_cmd_err |-> o_cmd_valid
  );

endmodule

// ==== verilog/regf_config.svh ====
// Array size, register locations, descriptor bases and command attribute codes
`ifndef REGF_CONFIG_SVH
`define REGF_CONFIG_SVH

////////////////////////////////////////////////////////////
// Array geometry
`define REGF_DEPTH          512
`define REGF_AW             9

////////////////////////////////////////////////////////////
// Single-byte register locations
`define REGF_TARGET_ADDR    9'd0    // Target address, bit 0 is RnW
`define REGF_NUM_FRAMES     9'd1
`define REGF_TGTS_COUNT     9'd35   // Targets known for role handoff
`define REGF_BDCST_ADDR     9'd46   // 7'h7E + W
`define REGF_ARB_ADDR       9'd48   // Arbitrated IBI address
`define REGF_IBI_CFG        9'd101
`define REGF_IBI_PAYLOAD    9'd102
`define REGF_ENEC_BYTE      9'd402  // ENINT, ENCR, ENHJ
`define REGF_DISEC_BYTE     9'd404  // DISINT, DISCR, DISHJ
`define REGF_HJ_CFG         9'd405
`define REGF_CRCAP1         9'd409

////////////////////////////////////////////////////////////
// Descriptor bases, 8 bytes each
`define REGF_NORMAL_DESC    9'd256
`define REGF_DUMMY_DESC     9'd450  // Fixed, loaded at reset

// Command attribute codes
`define REGF_ATTR_REGULAR   3'd0
`define REGF_ATTR_IMMEDIATE 3'd1

`endif

// ==== verilog/regf_pkg.sv ====
// Descriptor second-DWORD views and the union that overlays them
package regf_pkg;

  ////////////////////////////////////////////////////////////
  // Regular transfer: length on top, low half unused
  typedef struct packed {
    logic [15:0] data_len;  // Bytes to move
    logic [15:0] rsvd;
  } regf_xfer_dw1_s;

  // Immediate transfer: up to four data bytes inline
  typedef struct packed {
    logic [7:0] data3;
    logic [7:0] data2;
    logic [7:0] data1;
    logic [7:0] data0;      // First byte on the bus
  } regf_imm_dw1_s;

  // Same word, decoded by command attribute
  typedef union packed {
    regf_xfer_dw1_s xfer;
    regf_imm_dw1_s  imm;
  } regf_dw1_u;

endpackage

// ==== verilog/regf_storage.sv ====
// Register file array with reset defaults, hot-join upkeep, live outputs and descriptor view
`timescale 1ns/100ps
`include "regf_config.svh"

module regf_storage (
  input  logic                i_regf_clk,
  input  logic                i_regf_rst_n,
  input  logic                i_regf_rd_en,
  input  logic                i_regf_wr_en,
  input  logic [`REGF_AW-1:0] i_regf_addr,
  input  logic [7:0]          i_regf_data_wr,
  input  logic                i_engine_dummy_sel,       // Pick dummy descriptor
  output logic [7:0]          o_regf_data_rd,
  output logic                o_regf_wr_ro,
  output logic [31:0]         o_desc_dw0,
  output regf_pkg::regf_dw1_u o_desc_dw1,
  output logic [7:0]          o_regf_num_frames,
  output logic                o_ser_rx_tx,
  output logic [7:0]          o_regf_ibi_cfg,
  output logic [7:0]          o_regf_ibi_payload_size,
  output logic [7:0]          o_ibi_tgt_address,
  output logic [7:0]          o_crh_tgts_count,
  output logic [2:0]          o_regf_hj_cfg,
  output logic                o_regf_hj_support
);

  // Defaults shared by the array and the live copies
  localparam logic [7:0] DEF_TARGET = 8'hA8;
  localparam logic [7:0] DEF_FRAMES = 8'h02;
  localparam logic [7:0] DEF_ARB    = 8'h53;
  localparam logic [7:0] DEF_IBI    = 8'h01;
  localparam logic [7:0] DEF_PLOAD  = 8'h03;
  localparam logic [7:0] DEF_TGTS   = 8'h02;
  localparam logic [7:0] DEF_HJ_CFG = 8'h07;
  localparam logic [7:0] DEF_CRCAP1 = 8'h00;

  logic [7:0]          mem [`REGF_DEPTH];
  logic [`REGF_AW-1:0] desc_base;
  logic                hj_on;       // Hot-join supported and enabled

  ////////////////////////////////////////////////////////////
  // Read-only decode: defining bytes and dummy descriptor
  assign o_regf_wr_ro = (i_regf_addr == `REGF_ENEC_BYTE)  ||
                        (i_regf_addr == `REGF_DISEC_BYTE) ||
                        ((i_regf_addr >= `REGF_DUMMY_DESC) &&
                         (i_regf_addr <  `REGF_DUMMY_DESC + 9'd8));

  assign hj_on = mem[`REGF_CRCAP1][0] & mem[`REGF_HJ_CFG][1];

  // Array, host port and ENHJ/DISHJ upkeep
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      for (int i = 0; i < `REGF_DEPTH; i++)
        mem[i] <= 8'h00;
      mem[`REGF_TARGET_ADDR] <= DEF_TARGET;
      mem[`REGF_NUM_FRAMES]  <= DEF_FRAMES;
      mem[`REGF_TGTS_COUNT]  <= DEF_TGTS;
      mem[`REGF_BDCST_ADDR]  <= 8'hFC;          // 7'h7E + W
      mem[`REGF_ARB_ADDR]    <= DEF_ARB;
      mem[`REGF_IBI_CFG]     <= DEF_IBI;        // ACK + MDB
      mem[`REGF_IBI_PAYLOAD] <= DEF_PLOAD;
      mem[`REGF_ENEC_BYTE]   <= 8'h0B;
      mem[`REGF_DISEC_BYTE]  <= 8'h00;
      mem[`REGF_HJ_CFG]      <= DEF_HJ_CFG;
      mem[`REGF_CRCAP1]      <= DEF_CRCAP1;
      mem[`REGF_DUMMY_DESC]         <= 8'h81;  // Dummy DWORD0
      mem[`REGF_DUMMY_DESC + 9'd1]  <= 8'h8F;
      mem[`REGF_DUMMY_DESC + 9'd3]  <= 8'h18;
      o_regf_data_rd <= 8'h00;
    end
    else
    begin
      if (i_regf_rd_en)
        o_regf_data_rd <= mem[i_regf_addr];
      if (i_regf_wr_en && !o_regf_wr_ro)
        mem[i_regf_addr] <= i_regf_data_wr;   // Read-only writes dropped
      mem[`REGF_ENEC_BYTE][3]  <= hj_on;      // ENHJ
      mem[`REGF_DISEC_BYTE][3] <= ~hj_on;     // DISHJ
    end
  end

  ////////////////////////////////////////////////////////////
  // Live configuration copies, refreshed every cycle
  always_ff @(posedge i_regf_clk or negedge i_regf_rst_n)
  begin
    if (!i_regf_rst_n)
    begin
      o_regf_num_frames       <= DEF_FRAMES;
      o_ser_rx_tx             <= DEF_TARGET[0];
      o_regf_ibi_cfg          <= DEF_IBI;
      o_regf_ibi_payload_size <= DEF_PLOAD;
      o_ibi_tgt_address       <= DEF_ARB;
      o_crh_tgts_count        <= DEF_TGTS;
      o_regf_hj_cfg           <= DEF_HJ_CFG[2:0];
      o_regf_hj_support       <= DEF_CRCAP1[0];
    end
    else
    begin
      o_regf_num_frames       <= mem[`REGF_NUM_FRAMES];
      o_ser_rx_tx             <= mem[`REGF_TARGET_ADDR][0];  // RnW of target
      o_regf_ibi_cfg          <= mem[`REGF_IBI_CFG];
      o_regf_ibi_payload_size <= mem[`REGF_IBI_PAYLOAD];
      o_ibi_tgt_address       <= mem[`REGF_ARB_ADDR];
      o_crh_tgts_count        <= mem[`REGF_TGTS_COUNT];
      o_regf_hj_cfg           <= mem[`REGF_HJ_CFG][2:0];
      o_regf_hj_support       <= mem[`REGF_CRCAP1][0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Descriptor words, little-endian from the selected base
  assign desc_base = i_engine_dummy_sel ? `REGF_DUMMY_DESC : `REGF_NORMAL_DESC;

  assign o_desc_dw0 = {mem[desc_base + 9'd3], mem[desc_base + 9'd2],
                       mem[desc_base + 9'd1], mem[desc_base]};

  always_comb
  begin
    o_desc_dw1.imm.data0 = mem[desc_base + 9'd4];
    o_desc_dw1.imm.data1 = mem[desc_base + 9'd5];
    o_desc_dw1.imm.data2 = mem[desc_base + 9'd6];
    o_desc_dw1.imm.data3 = mem[desc_base + 9'd7];
  end

  // Host port strobes are exclusive
  a_rd_wr_exclusive : assert property (
    @(posedge i_regf_clk) disable iff (!i_regf_rst_n)
    !(i_regf_rd_en && i_regf_wr_en)
  );

endmodule
